//--- list.f
+incdir+design
design/mmc3_bus_pkg.sv
design/mmc3_state_pkg.sv
design/mmc3_regs.sv
design/mmc3_prg_map.sv
design/mmc3_chr_map.sv
design/mmc3_scanline_irq.sv
design/mmc3_top.sv
test/mmc3_chk.sv
test/mmc3_tb.sv

//--- test/mmc3_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MMC3 mapper testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mmc3_settings.svh"

module mmc3_tb;

	localparam int CLK_PERIOD  = 20;
	localparam int RAND_N      = 24;  // Random accesses per group
	localparam int GAP         = 16;  // A12 low cycles before a pulse counts
	localparam int STIM_CYCLES = 16 + 2 * (10 + RAND_N) + 4 * (26 + RAND_N)
		+ 16 * (GAP + 1) + 128;   // Sum over all behaviors, rounded up

	// Expected scanline counter state
	typedef struct packed {
		logic [7:0] latch;
		logic [7:0] counter;
		logic       reload;   // $C001 pending
		logic       enable;
		logic [3:0] cool;     // A12 filter
		logic       irq;
	} irq_model_t;

	logic                       clk;
	logic                       arst_n;
	logic                       ce;
	mmc3_bus_pkg::cpu_bus_t     cpu;
	logic [`MMC3_PPU_AW-1:0]    ppu_addr;
	logic                       chr_ram;
	mmc3_bus_pkg::prg_out_t     prg;
	mmc3_bus_pkg::chr_out_t     chr;
	logic                       irq;
	mmc3_state_pkg::bank_regs_t m_regs;           // Expected register state
	logic [2:0]                 m_sel;            // Expected bank index
	irq_model_t                 m_irq;
	int                         error_count = 0;
	logic [31:0]                rnd;

	mmc3_top dut0 (
		.clk      (clk),
		.arst_n   (arst_n),
		.ce       (ce),
		.cpu      (cpu),
		.ppu_addr (ppu_addr),
		.chr_ram  (chr_ram),
		.prg      (prg),
		.chr      (chr),
		.irq      (irq)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// $8000 slots by mode, $6000 window by enable and protect
	function automatic mmc3_bus_pkg::prg_out_t ref_prg(mmc3_state_pkg::bank_regs_t r,
			mmc3_bus_pkg::cpu_bus_t c);
		logic [5:0]             bank;
		logic                   ram;
		mmc3_bus_pkg::prg_out_t o;
		case (c.addr[14:13])
			2'd0: bank = r.prg_mode ? 6'h3e : r.prg_bank_0;
			2'd1: bank = r.prg_bank_1;
			2'd2: bank = r.prg_mode ? r.prg_bank_0 : 6'h3e;
			default: bank = 6'h3f;  // Last bank
		endcase
		ram     = (c.addr[15:13] == 3'b011) && r.ram_enable && !(c.write && r.ram_protect);
		o.allow = ram || (c.addr[15] && !c.write);
		o.aout  = ram ? {9'b111100000, c.addr[12:0]} : {3'b000, bank, c.addr[12:0]};
		return o;
	endfunction

	function automatic mmc3_bus_pkg::chr_out_t ref_chr(mmc3_state_pkg::bank_regs_t r,
			logic [13:0] a, logic ram);
		logic [7:0]             bank;
		mmc3_bus_pkg::chr_out_t o;
		if (!(a[12] ^ r.chr_invert))
			bank = {(a[11] ? r.chr_bank_1 : r.chr_bank_0), a[10]};  // 2 KB half
		else if (a[11])
			bank = a[10] ? r.chr_bank_5 : r.chr_bank_4;
		else
			bank = a[10] ? r.chr_bank_3 : r.chr_bank_2;
		o.aout     = {3'b100, 1'b0, bank, a[9:0]};
		o.allow    = ram;
		o.vram_a10 = r.mirroring ? a[10] : a[11];
		o.vram_ce  = a[13];
		return o;
	endfunction

	// One clk edge of the counter, CPU commands applied last
	function automatic irq_model_t ref_irq_step(irq_model_t s, logic ce_in, logic a12,
			mmc3_bus_pkg::cpu_bus_t c);
		irq_model_t n;
		n = s;
		if (ce_in && a12 && s.cool == 4'd0) begin
			n.counter = (s.counter == 8'd0 || s.reload) ? s.latch : s.counter - 8'd1;
			n.reload  = 1'b0;
			if (n.counter == 8'd0 && s.enable)
				n.irq = 1'b1;
		end
		if (ce_in)
			n.cool = a12 ? 4'd15 : ((s.cool != 4'd0) ? s.cool - 4'd1 : 4'd0);
		if (ce_in && c.write && c.addr[15] && c.addr[14]) begin
			case ({c.addr[13], c.addr[0]})
				2'b00: n.latch = c.data;
				2'b01: n.reload = 1'b1;
				2'b10: begin
					n.enable = 1'b0;
					n.irq    = 1'b0;
				end
				default: n.enable = 1'b1;
			endcase
		end
		return n;
	endfunction

	task automatic track_write(input mmc3_bus_pkg::cpu_bus_t c);
		if (c.addr[15]) begin
			case ({c.addr[14:13], c.addr[0]})
				3'b000: begin
					m_regs.chr_invert = c.data[7];
					m_regs.prg_mode   = c.data[6];
					m_sel             = c.data[2:0];
				end
				3'b001: begin
					case (m_sel)
						3'd0: m_regs.chr_bank_0 = c.data[7:1];
						3'd1: m_regs.chr_bank_1 = c.data[7:1];
						3'd2: m_regs.chr_bank_2 = c.data;
						3'd3: m_regs.chr_bank_3 = c.data;
						3'd4: m_regs.chr_bank_4 = c.data;
						3'd5: m_regs.chr_bank_5 = c.data;
						3'd6: m_regs.prg_bank_0 = c.data[5:0];
						default: m_regs.prg_bank_1 = c.data[5:0];
					endcase
				end
				3'b010: m_regs.mirroring = ~c.data[0];
				3'b011: begin
					m_regs.ram_enable  = c.data[7];
					m_regs.ram_protect = c.data[6];
				end
				default: ;
			endcase
		end
	endtask

	task automatic check_prg(input string name, input mmc3_bus_pkg::prg_out_t exp,
			input mmc3_bus_pkg::prg_out_t got);
		if (got.allow !== exp.allow || (exp.allow && got.aout !== exp.aout)) begin
			error_count++;
			$display("FAILED %s expected %h got %h", name, exp, got);
			$display("SOME TESTS FAILED");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic check_chr(input string name, input mmc3_bus_pkg::chr_out_t exp,
			input mmc3_bus_pkg::chr_out_t got);
		if (got !== exp) begin
			error_count++;
			$display("FAILED %s expected %h got %h", name, exp, got);
			$display("SOME TESTS FAILED");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic check_irq(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			error_count++;
			$display("FAILED %s expected %h got %h", name, exp, got);
			$display("SOME TESTS FAILED");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge clk);
		cpu = {addr, data, 1'b1};
		@(negedge clk);
		cpu.write = 1'b0;  // Single store
	endtask

	task automatic bus_access(input logic [15:0] addr, input logic [7:0] data, input logic wr);
		@(negedge clk);
		cpu = {addr, data, wr};
	endtask

	task automatic ppu_access(input logic [13:0] addr, input logic ram);
		@(negedge clk);
		cpu.write = 1'b0;
		ppu_addr  = addr;
		chr_ram   = ram;
	endtask

	task automatic a12_pulse(input int gap);
		@(negedge clk);
		cpu.write = 1'b0;
		ppu_addr  = 14'h1000;  // One cycle high
		@(negedge clk);
		ppu_addr  = 14'h0000;
		repeat (gap - 1) @(negedge clk);
	endtask

	// Model follows every edge, outputs compared just after it
	initial begin
		forever begin
			@(posedge clk);
			if (!arst_n) begin
				m_regs = '0;
				m_sel  = '0;
				m_irq  = '0;
			end else begin
				m_irq = ref_irq_step(m_irq, ce, ppu_addr[12], cpu);
				if (ce && cpu.write)
					track_write(cpu);
			end
			#1;
			check_prg("prg", ref_prg(m_regs, cpu), prg);
			check_chr("chr", ref_chr(m_regs, ppu_addr, chr_ram), chr);
			check_irq("irq", m_irq.irq, irq);
			if (dut0.chk0.fail_count != 0) begin
				error_count++;
				$display("An assertion in the bound checker failed");
				$display("SOME TESTS FAILED");
				$fatal(1, "assertion failure");
			end
		end
	end

	initial begin
		#(STIM_CYCLES * CLK_PERIOD * 2);
		$display("Run did not finish in time, watchdog expired");
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog timeout");
	end

	initial begin
		rnd      = $urandom(32'hcd1f);
		arst_n   = 1'b0;
		ce       = 1'b1;
		cpu      = '0;
		ppu_addr = '0;
		chr_ram  = 1'b0;
		repeat (8) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);

		// Reset mapping
		check_irq("irq", 1'b0, irq);
		bus_access(16'h8000, 8'h00, 1'b0);
		#1 check_prg("prg", {22'h0, 1'b1}, prg);
		bus_access(16'hC000, 8'h00, 1'b0);
		#1 check_prg("prg", {3'b000, 6'h3e, 13'h0, 1'b1}, prg);
		bus_access(16'hE000, 8'h00, 1'b0);
		#1 check_prg("prg", {3'b000, 6'h3f, 13'h0, 1'b1}, prg);
		bus_access(16'h6000, 8'h00, 1'b0);
		#1 check_prg("prg", {22'h0, 1'b0}, prg);

		// PRG banks in both modes
		for (int mode = 0; mode < 2; mode++) begin
			rnd = $urandom;
			bus_write(16'h8000, {rnd[7], mode[0], 3'b000, 3'd6});
			bus_write(16'h8001, rnd[15:8]);
			bus_write(16'h8000, {rnd[7], mode[0], 3'b000, 3'd7});
			bus_write(16'h8001, rnd[23:16]);
			bus_write(16'hA001, rnd[31:24]);  // Random RAM control
			repeat (RAND_N) begin
				rnd = $urandom;
				bus_access({rnd[15] & ~rnd[24], rnd[14:0]}, rnd[23:16], rnd[24]);
			end
		end

		// CHR banks, inversion and mirroring
		for (int inv = 0; inv < 2; inv++) begin
			for (int mir = 0; mir < 2; mir++) begin
				for (int b = 0; b < 6; b++) begin
					rnd = $urandom;
					bus_write(16'h8000, {inv[0], 4'b0000, b[2:0]});
					bus_write(16'h8001, rnd[7:0]);
				end
				bus_write(16'hA000, {7'h00, mir[0]});
				repeat (RAND_N) begin
					rnd = $urandom;
					ppu_access(rnd[13:0], rnd[16]);
				end
			end
		end

		// PRG-RAM window
		bus_write(16'hA001, 8'h00);
		bus_access(16'h6123, 8'h55, 1'b0);
		#1 check_prg("prg", {22'h0, 1'b0}, prg);
		bus_write(16'hA001, 8'h80);
		bus_access(16'h7abc, 8'h55, 1'b0);
		#1 check_prg("prg", {9'h1e0, 13'h1abc, 1'b1}, prg);
		bus_access(16'h6001, 8'h55, 1'b1);
		#1 check_prg("prg", {9'h1e0, 13'h0001, 1'b1}, prg);
		bus_write(16'hA001, 8'hC0);
		bus_access(16'h6001, 8'h55, 1'b1);
		#1 check_prg("prg", {22'h0, 1'b0}, prg);
		bus_access(16'h7fff, 8'h55, 1'b0);
		#1 check_prg("prg", {9'h1e0, 13'h1fff, 1'b1}, prg);

		// Scanline counter with latch 3
		ppu_access(14'h0000, 1'b0);
		repeat (GAP) @(negedge clk);  // Filter drained
		bus_write(16'hE000, 8'h00);
		bus_write(16'hC000, 8'd3);
		bus_write(16'hC001, 8'h00);
		bus_write(16'hE001, 8'h00);
		a12_pulse(4);                 // Reload to 3, then too short a gap
		a12_pulse(GAP);               // Filtered out
		a12_pulse(GAP);
		a12_pulse(GAP);
		check_irq("irq", 1'b0, irq);
		a12_pulse(GAP);               // Pulse N+1
		check_irq("irq", 1'b1, irq);
		bus_write(16'hE000, 8'h00);
		check_irq("irq", 1'b0, irq);

		// No counting while ce is low
		bus_write(16'hC000, 8'd1);
		bus_write(16'hC001, 8'h00);
		bus_write(16'hE001, 8'h00);
		ce = 1'b0;
		repeat (4) a12_pulse(GAP);    // Spaced enough to fire if counted
		ce = 1'b1;
		check_irq("irq", 1'b0, irq);
		a12_pulse(GAP);
		check_irq("irq", 1'b0, irq);
		a12_pulse(GAP);
		check_irq("irq", 1'b1, irq);
		bus_write(16'hE000, 8'h00);

		// Latch 0 fires on every clock
		bus_write(16'hC000, 8'd0);
		bus_write(16'hC001, 8'h00);
		bus_write(16'hE001, 8'h00);
		for (int k = 0; k < 4; k++) begin
			a12_pulse(GAP);
			check_irq("irq", m_irq.irq, irq);
			check_irq("irq", 1'b1, irq);
			bus_write(16'hE000, 8'h00);
			check_irq("irq", 1'b0, irq);
			bus_write(16'hE001, 8'h00);
		end
		bus_write(16'hE000, 8'h00);
		a12_pulse(GAP);
		check_irq("irq", 1'b0, irq);  // Disabled stays quiet

		repeat (2) @(negedge clk);
		if (error_count == 0 && dut0.chk0.fail_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- test/mmc3_chk.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MMC3 mapper assertions
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mmc3_chk (
	input logic                       clk,
	input logic                       arst_n,
	input mmc3_bus_pkg::cpu_bus_t     cpu,
	input mmc3_bus_pkg::prg_out_t     prg,
	input mmc3_state_pkg::bank_regs_t regs,
	input logic                       ram_sel,  // PRG-RAM hit
	input logic                       irq
);

	int fail_count = 0;  // Failed assertions so far

	a_irq_reset: assert property (@(posedge clk) !arst_n |-> !irq) else begin
		fail_count++;
		$error("irq high while reset is asserted");
	end

	// ROM space is read only
	a_rom_write: assert property (@(posedge clk) disable iff (!arst_n)
		(cpu.write && cpu.addr[15]) |-> !prg.allow) else begin
		fail_count++;
		$error("write at or above 8000 was allowed");
	end

	a_ram_protect: assert property (@(posedge clk) disable iff (!arst_n)
		(cpu.write && regs.ram_protect) |-> !ram_sel) else begin
		fail_count++;
		$error("protected PRG-RAM write reached the RAM");
	end

endmodule

bind mmc3_top mmc3_chk chk0 (
	.clk     (clk),
	.arst_n  (arst_n),
	.cpu     (cpu),
	.prg     (prg),
	.regs    (regs),
	.ram_sel (ram_sel),
	.irq     (irq)
);

//--- design/mmc3_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MMC3 mapper top
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mmc3_settings.svh"

module mmc3_top (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    ce,        // M2 enable
	input  mmc3_bus_pkg::cpu_bus_t  cpu,
	input  logic [`MMC3_PPU_AW-1:0] ppu_addr,
	input  logic                    chr_ram,   // CHR is RAM on this board
	output mmc3_bus_pkg::prg_out_t  prg,
	output mmc3_bus_pkg::chr_out_t  chr,
	output logic                    irq
);

	mmc3_state_pkg::bank_regs_t regs;     // Banking state
	mmc3_state_pkg::irq_cmd_t   irq_cmd;  // $C000-$E001 strobes
	logic                       ram_sel;  // PRG-RAM hit

	mmc3_regs u_regs (
		.clk     (clk),
		.arst_n  (arst_n),
		.ce      (ce),
		.cpu     (cpu),
		.regs    (regs),
		.irq_cmd (irq_cmd)
	);

	mmc3_prg_map u_prg_map (
		.cpu     (cpu),
		.regs    (regs),
		.prg     (prg),
		.ram_sel (ram_sel)
	);

	mmc3_chr_map u_chr_map (
		.ppu_addr (ppu_addr),
		.chr_ram  (chr_ram),
		.regs     (regs),
		.chr      (chr)
	);

	mmc3_scanline_irq u_irq (
		.clk    (clk),
		.arst_n (arst_n),
		.ce     (ce),
		.a12    (ppu_addr[12]),  // Sprite fetch edge per scanline
		.cmd    (irq_cmd),
		.irq    (irq)
	);

endmodule

//--- design/mmc3_scanline_irq.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MMC3 scanline IRQ counter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mmc3_settings.svh"

module mmc3_scanline_irq (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     ce,    // M2 enable
	input  logic                     a12,   // PPU A12
	input  mmc3_state_pkg::irq_cmd_t cmd,
	output logic                     irq
);

	logic [7:0] latch;        // Reload value from $C000
	logic [7:0] counter;      // Scanline count
	logic [7:0] next_count;   // Value taken on a counter clock
	logic       reload_pend;  // $C001 seen since last clock
	logic       irq_en;       // Set by $E001
	logic [3:0] cool;         // A12 low time filter
	logic       count_clk;    // Filtered A12 rise

	// A12 only counts after a long enough low period
	assign count_clk  = ce && a12 && (cool == 4'd0);
	assign next_count = (counter == 8'd0 || reload_pend) ? latch : counter - 8'd1;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			latch       <= '0;
			counter     <= '0;
			reload_pend <= 1'b0;
			irq_en      <= 1'b0;
			cool        <= '0;
			irq         <= 1'b0;
		end else begin
			if (ce) begin
				if (a12)
					cool <= `MMC3_A12_COOL;  // Rearm while high
				else if (cool != 4'd0)
					cool <= cool - 4'd1;
			end

			// New behavior fires whenever the count lands on zero
			if (count_clk) begin
				counter     <= next_count;
				reload_pend <= 1'b0;
				if (next_count == 8'd0 && irq_en)
					irq <= 1'b1;
			end

			// CPU commands win over the counter clock
			if (cmd.latch_wr)
				latch <= cmd.data;
			if (cmd.reload_wr)
				reload_pend <= 1'b1;
			if (cmd.enable_wr)
				irq_en <= 1'b1;
			if (cmd.disable_wr) begin
				irq_en <= 1'b0;
				irq    <= 1'b0;  // Acknowledge
			end
		end
	end

endmodule

//--- design/mmc3_chr_map.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MMC3 CHR address map
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mmc3_settings.svh"

module mmc3_chr_map (
	input  logic [`MMC3_PPU_AW-1:0]    ppu_addr,
	input  logic                       chr_ram,   // Cart has CHR RAM
	input  mmc3_state_pkg::bank_regs_t regs,
	output mmc3_bus_pkg::chr_out_t     chr
);

	logic                        a12_eff;   // Pattern table half after inversion
	logic [`MMC3_CHR_BANK_W-1:0] chr_bank;  // 1 KB bank number

	assign a12_eff = ppu_addr[12] ^ regs.chr_invert;

	always_comb begin
		casez ({a12_eff, ppu_addr[11:10]})
			3'b00?:  chr_bank = {regs.chr_bank_0, ppu_addr[10]};  // 2 KB halves
			3'b01?:  chr_bank = {regs.chr_bank_1, ppu_addr[10]};
			3'b100:  chr_bank = regs.chr_bank_2;
			3'b101:  chr_bank = regs.chr_bank_3;
			3'b110:  chr_bank = regs.chr_bank_4;
			default: chr_bank = regs.chr_bank_5;
		endcase
	end

	always_comb begin
		chr.aout     = {`MMC3_CHR_ROM_BASE, 1'b0, chr_bank, ppu_addr[9:0]};  // Bank bit 8 unused
		chr.allow    = chr_ram;
		chr.vram_a10 = regs.mirroring ? ppu_addr[10] : ppu_addr[11];
		chr.vram_ce  = ppu_addr[13];  // Nametables at $2000 and up
	end

endmodule

//--- design/mmc3_prg_map.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MMC3 PRG address map
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mmc3_settings.svh"

module mmc3_prg_map (
	input  mmc3_bus_pkg::cpu_bus_t     cpu,
	input  mmc3_state_pkg::bank_regs_t regs,
	output mmc3_bus_pkg::prg_out_t     prg,
	output logic                       ram_sel  // Access goes to PRG-RAM
);

	logic [`MMC3_PRG_BANK_W-1:0] prg_bank;  // 8 KB bank for this slot
	logic                        ram_win;   // $6000-$7FFF

	// Slot from A14 A13, mode swaps the two outer switchable slots
	always_comb begin
		case ({cpu.addr[14:13], regs.prg_mode})
			3'b00_0: prg_bank = regs.prg_bank_0;      // $8000 R6
			3'b00_1: prg_bank = `MMC3_PRG_SLAST;      // $8000 fixed
			3'b01_0,
			3'b01_1: prg_bank = regs.prg_bank_1;      // $A000 R7 in both modes
			3'b10_0: prg_bank = `MMC3_PRG_SLAST;      // $C000 fixed
			3'b10_1: prg_bank = regs.prg_bank_0;      // $C000 R6
			default: prg_bank = `MMC3_PRG_LAST;       // $E000 always last
		endcase
	end

	assign ram_win = (cpu.addr[15:13] == 3'b011);
	assign ram_sel = ram_win && regs.ram_enable && !(regs.ram_protect && cpu.write);

	always_comb begin
		prg.allow = (cpu.addr[15] && !cpu.write) || ram_sel;  // ROM is read only
		if (ram_sel)
			prg.aout = {`MMC3_PRG_RAM_BASE, cpu.addr[12:0]};
		else
			prg.aout = {3'b000, prg_bank, cpu.addr[12:0]};
	end

endmodule

//--- design/mmc3_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MMC3 CPU register file
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mmc3_settings.svh"

module mmc3_regs (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       ce,       // M2 enable
	input  mmc3_bus_pkg::cpu_bus_t     cpu,
	output mmc3_state_pkg::bank_regs_t regs,
	output mmc3_state_pkg::irq_cmd_t   irq_cmd
);

	logic [2:0] bank_sel;  // Target of the next bank data write
	logic       reg_wr;    // Store into $8000-$FFFF this cycle
	logic [2:0] reg_addr;  // A14 A13 A0 picks the register

	assign reg_wr   = ce && cpu.write && cpu.addr[15];
	assign reg_addr = {cpu.addr[14:13], cpu.addr[0]};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bank_sel <= '0;
			regs     <= '0;
		end else if (reg_wr) begin
			case (reg_addr)
				3'b00_0: begin  // $8000 bank select
					regs.chr_invert <= cpu.data[7];
					regs.prg_mode   <= cpu.data[6];
					bank_sel        <= cpu.data[2:0];
				end
				3'b00_1: begin  // $8001 bank data
					case (bank_sel)
						3'd0: regs.chr_bank_0 <= cpu.data[7:1];  // 2 KB, even banks only
						3'd1: regs.chr_bank_1 <= cpu.data[7:1];
						3'd2: regs.chr_bank_2 <= cpu.data;
						3'd3: regs.chr_bank_3 <= cpu.data;
						3'd4: regs.chr_bank_4 <= cpu.data;
						3'd5: regs.chr_bank_5 <= cpu.data;
						3'd6: regs.prg_bank_0 <= cpu.data[`MMC3_PRG_BANK_W-1:0];
						3'd7: regs.prg_bank_1 <= cpu.data[`MMC3_PRG_BANK_W-1:0];
					endcase
				end
				3'b01_0: regs.mirroring <= !cpu.data[0];  // $A000, 0 written means vertical
				3'b01_1: begin  // $A001 PRG-RAM protect
					regs.ram_enable  <= cpu.data[7];
					regs.ram_protect <= cpu.data[6];
				end
				default: ;  // $C000-$FFFF handled by the counter
			endcase
		end
	end

	// IRQ registers go out as strobes
	always_comb begin
		irq_cmd.latch_wr   = reg_wr && (reg_addr == 3'b10_0);  // $C000
		irq_cmd.reload_wr  = reg_wr && (reg_addr == 3'b10_1);  // $C001
		irq_cmd.disable_wr = reg_wr && (reg_addr == 3'b11_0);  // $E000
		irq_cmd.enable_wr  = reg_wr && (reg_addr == 3'b11_1);  // $E001
		irq_cmd.data       = cpu.data;
	end

endmodule

//--- design/mmc3_state_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MMC3 register state types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mmc3_settings.svh"

package mmc3_state_pkg;

	// Banking and RAM control as written by the CPU
	typedef struct packed {
		// 2 KB banks, low bit comes from PPU A10
		logic [`MMC3_CHR_BANK_W-2:0] chr_bank_0;  // R0
		logic [`MMC3_CHR_BANK_W-2:0] chr_bank_1;  // R1
		// 1 KB banks
		logic [`MMC3_CHR_BANK_W-1:0] chr_bank_2;  // R2
		logic [`MMC3_CHR_BANK_W-1:0] chr_bank_3;  // R3
		logic [`MMC3_CHR_BANK_W-1:0] chr_bank_4;  // R4
		logic [`MMC3_CHR_BANK_W-1:0] chr_bank_5;  // R5
		logic [`MMC3_PRG_BANK_W-1:0] prg_bank_0;  // R6, swaps with $C000
		logic [`MMC3_PRG_BANK_W-1:0] prg_bank_1;  // R7, always $A000
		logic                        prg_mode;    // Swap $8000 and $C000
		logic                        chr_invert;  // Flip PPU A12
		logic                        mirroring;   // Set selects A10 for CIRAM
		logic                        ram_enable;  // Open $6000 window
		logic                        ram_protect; // Block stores to window
	} bank_regs_t;

	// Single cycle commands to the scanline counter
	typedef struct packed {
		logic       latch_wr;    // $C000
		logic       reload_wr;   // $C001
		logic       disable_wr;  // $E000
		logic       enable_wr;   // $E001
		logic [7:0] data;        // Store data for the latch
	} irq_cmd_t;

endpackage

//--- design/mmc3_bus_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MMC3 bus types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mmc3_settings.svh"

package mmc3_bus_pkg;

	// CPU access as the cart sees it
	typedef struct packed {
		logic [`MMC3_CPU_AW-1:0] addr;   // 6502 address
		logic [7:0]              data;   // Store data
		logic                    write;  // High on a store
	} cpu_bus_t;

	// Mapped CPU access
	typedef struct packed {
		logic [`MMC3_OUT_AW-1:0] aout;   // PRG-ROM or PRG-RAM address
		logic                    allow;  // Memory may act on this access
	} prg_out_t;

	// Mapped PPU access
	typedef struct packed {
		logic [`MMC3_OUT_AW-1:0] aout;      // CHR address
		logic                    allow;     // CHR write permit
		logic                    vram_a10;  // CIRAM A10
		logic                    vram_ce;   // Goes to internal 2 KB VRAM
	} chr_out_t;

endpackage

//--- design/mmc3_settings.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MMC3 mapper constants
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MMC3_SETTINGS_SVH
`define MMC3_SETTINGS_SVH

// NES side buses
`define MMC3_CPU_AW        16             // 6502 address bus
`define MMC3_PPU_AW        14             // PPU address bus
`define MMC3_OUT_AW        22             // Cart memory address space

// Bank number widths
`define MMC3_PRG_BANK_W    6              // Up to 64 PRG banks of 8 KB
`define MMC3_CHR_BANK_W    8              // Up to 256 CHR banks of 1 KB

// Hard-wired PRG banks
`define MMC3_PRG_LAST      6'b111111      // Always at $E000
`define MMC3_PRG_SLAST     6'b111110      // At $C000 or $8000 by mode

// A12 filter
`define MMC3_A12_COOL      4'd15          // Low ce cycles before next edge counts

// Placement inside the output space
`define MMC3_PRG_RAM_BASE  9'b111100000   // Top bits of the 8 KB PRG-RAM window
`define MMC3_CHR_ROM_BASE  3'b100         // Top bits of CHR space

`endif
